// ==== hdl/fifo_cfg_pkg.sv ====
// FIFO configuration defaults
// Sizes and flag offsets used by the top level as parameter defaults

package fifo_cfg_pkg;

    localparam int DEF_DATA_WIDTH         = 8; // Bits per data word
    localparam int DEF_PTR_WIDTH          = 4; // Address bits, depth is 2**DEF_PTR_WIDTH

    // Flag thresholds, in words
    localparam int DEF_ALMOSTFULL_OFFSET  = 1; // Distance from full that raises almost full
    localparam int DEF_ALMOSTEMPTY_OFFSET = 1; // Fill at or below this raises almost empty

endpackage : fifo_cfg_pkg

// ==== hdl/fifo_ptr_pkg.sv ====
// FIFO pointer definitions
// Pointer word type with wrap bit and the Gray/binary conversions
// shared by both pointer controllers

package fifo_ptr_pkg;

    localparam int PTR_MAX_WIDTH = 16; // Largest supported address width

    // Address bits plus the wrap bit; modules use the low PTR_WIDTH+1 bits
    typedef logic [PTR_MAX_WIDTH:0] ptr_word_t;

    // Binary to reflected Gray code
    function automatic ptr_word_t bin_to_gray(input ptr_word_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Gray code back to binary, prefix XOR from the top bit down
    function automatic ptr_word_t gray_to_bin(input ptr_word_t gray);
        ptr_word_t bin;
        bin[PTR_MAX_WIDTH] = gray[PTR_MAX_WIDTH];
        for (int i = PTR_MAX_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage : fifo_ptr_pkg

// ==== hdl/fifo_mem_if.sv ====
// FIFO storage interface
// Joins the write and read pointer controllers to the storage array

`timescale 1ns/10ps

interface fifo_mem_if #(
    parameter int DATA_WIDTH = 8,
    parameter int PTR_WIDTH  = 4
);

    logic                  wen;    // Store wdata at waddr on the next write edge
    logic [PTR_WIDTH-1:0]  waddr;
    logic [DATA_WIDTH-1:0] wdata;  // Tied to the top-level write data
    logic [PTR_WIDTH-1:0]  raddr;
    logic [DATA_WIDTH-1:0] rdata;  // Word at raddr, no latency

    modport wr_port (
        output wen,
        output waddr
    );

    modport rd_port (
        output raddr,
        input  rdata
    );

    modport mem_port (
        input  wen,
        input  waddr,
        input  wdata,
        input  raddr,
        output rdata
    );

endinterface : fifo_mem_if

// ==== hdl/fifo_dpram.sv ====
// FIFO storage array
// Synchronous write on the write clock, asynchronous read so the
// oldest word falls through to the read side

`timescale 1ns/10ps

module fifo_dpram #(
    parameter int DATA_WIDTH = 8,
    parameter int PTR_WIDTH  = 4
) (
    input  logic       i_wclk,
    fifo_mem_if.mem_port mem_if
);

    localparam int DEPTH = 1 << PTR_WIDTH;

    logic [DATA_WIDTH-1:0] mem [DEPTH];  // No reset, contents only valid once written

    always_ff @(posedge i_wclk) begin
        if (mem_if.wen) begin
            mem[mem_if.waddr] <= mem_if.wdata;
        end
    end

    // Read port
    assign mem_if.rdata = mem[mem_if.raddr];

endmodule : fifo_dpram

// ==== hdl/fifo_wr_ctrl.sv ====
// FIFO write pointer controller
// Holds the binary and Gray write pointers, brings the Gray read pointer
// in through two flops and derives full, almost full and the write fill
// Flags set at once on a write, clear late as the read pointer arrives

`timescale 1ns/10ps

module fifo_wr_ctrl import fifo_ptr_pkg::*; #(
    parameter int PTR_WIDTH         = 4,
    parameter int ALMOSTFULL_OFFSET = 1
) (
    input  logic               i_wclk,
    input  logic               i_wrstn,
    input  logic               i_wr,
    input  logic [PTR_WIDTH:0] i_rgray,       // Gray read pointer, read clock domain
    output logic [PTR_WIDTH:0] o_wgray,       // Registered Gray write pointer
    output logic               o_wfull,
    output logic               o_walmostfull,
    output logic [PTR_WIDTH:0] o_wfill,
    fifo_mem_if.wr_port        mem_if
);

    localparam int DEPTH = 1 << PTR_WIDTH;
    localparam logic [PTR_WIDTH:0] AF_LEVEL = (PTR_WIDTH+1)'(DEPTH - ALMOSTFULL_OFFSET);

    logic [PTR_WIDTH:0] wbin;          // Binary write pointer with wrap bit
    logic [PTR_WIDTH:0] wbin_next;
    logic [PTR_WIDTH:0] wgray_next;
    logic [PTR_WIDTH:0] wq1_rgray;     // Synchronizer stage 1
    logic [PTR_WIDTH:0] wq2_rgray;     // Synchronizer stage 2
    logic [PTR_WIDTH:0] wq2_rbin;
    logic [PTR_WIDTH:0] wfill_next;
    logic               wr_accept;
    logic               wfull_next;
    logic               walmostfull_next;
    ptr_word_t          wgray_next_w;
    ptr_word_t          wq2_rbin_w;

    assign wr_accept = i_wr & ~o_wfull;  // Writes while full are dropped

    assign wbin_next    = wbin + {{PTR_WIDTH{1'b0}}, wr_accept};
    assign wgray_next_w = bin_to_gray(ptr_word_t'(wbin_next));
    assign wgray_next   = wgray_next_w[PTR_WIDTH:0];

    // Read pointer back to binary for the fill level
    assign wq2_rbin_w = gray_to_bin(ptr_word_t'(wq2_rgray));
    assign wq2_rbin   = wq2_rbin_w[PTR_WIDTH:0];

    // Full when the write pointer is one lap ahead of the read pointer,
    // which in Gray code flips the top two bits
    assign wfull_next = (wgray_next ==
                         {~wq2_rgray[PTR_WIDTH:PTR_WIDTH-1], wq2_rgray[PTR_WIDTH-2:0]});

    // Subtraction modulo 2**(PTR_WIDTH+1) handles the pointer wrap
    assign wfill_next       = wbin_next - wq2_rbin;
    assign walmostfull_next = (wfill_next >= AF_LEVEL) || wfull_next;

    // Two-flop synchronizer for the read pointer
    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= i_rgray;
            wq2_rgray <= wq1_rgray;
        end
    end

    always_ff @(posedge i_wclk or negedge i_wrstn) begin
        if (!i_wrstn) begin
            wbin          <= '0;
            o_wgray       <= '0;
            o_wfull       <= 1'b0;
            o_walmostfull <= 1'b0;
            o_wfill       <= '0;
        end else begin
            wbin          <= wbin_next;
            o_wgray       <= wgray_next;
            o_wfull       <= wfull_next;
            o_walmostfull <= walmostfull_next;
            o_wfill       <= wfill_next;
        end
    end

    // Storage write port
    assign mem_if.wen   = wr_accept;
    assign mem_if.waddr = wbin[PTR_WIDTH-1:0];

endmodule : fifo_wr_ctrl

// ==== hdl/fifo_rd_ctrl.sv ====
// FIFO read pointer controller
// Holds the binary and Gray read pointers, brings the Gray write pointer
// in through two flops and derives empty, almost empty and the read fill
// Empty sets at once on the last read, clears late as writes arrive

`timescale 1ns/10ps

module fifo_rd_ctrl import fifo_ptr_pkg::*; #(
    parameter int PTR_WIDTH          = 4,
    parameter int ALMOSTEMPTY_OFFSET = 1
) (
    input  logic               i_rclk,
    input  logic               i_rrstn,
    input  logic               i_rd,
    input  logic [PTR_WIDTH:0] i_wgray,        // Gray write pointer, write clock domain
    output logic [PTR_WIDTH:0] o_rgray,        // Registered Gray read pointer
    output logic               o_rempty,
    output logic               o_ralmostempty,
    output logic [PTR_WIDTH:0] o_rfill,
    fifo_mem_if.rd_port        mem_if
);

    localparam logic [PTR_WIDTH:0] AE_LEVEL = (PTR_WIDTH+1)'(ALMOSTEMPTY_OFFSET);

    logic [PTR_WIDTH:0] rbin;          // Binary read pointer with wrap bit
    logic [PTR_WIDTH:0] rbin_next;
    logic [PTR_WIDTH:0] rgray_next;
    logic [PTR_WIDTH:0] rq1_wgray;     // Synchronizer stage 1
    logic [PTR_WIDTH:0] rq2_wgray;     // Synchronizer stage 2
    logic [PTR_WIDTH:0] rq2_wbin;
    logic [PTR_WIDTH:0] rfill_next;
    logic               rd_accept;
    logic               rempty_next;
    ptr_word_t          rgray_next_w;
    ptr_word_t          rq2_wbin_w;

    assign rd_accept = i_rd & ~o_rempty;  // Reads while empty are dropped

    assign rbin_next    = rbin + {{PTR_WIDTH{1'b0}}, rd_accept};
    assign rgray_next_w = bin_to_gray(ptr_word_t'(rbin_next));
    assign rgray_next   = rgray_next_w[PTR_WIDTH:0];

    assign rq2_wbin_w = gray_to_bin(ptr_word_t'(rq2_wgray));
    assign rq2_wbin   = rq2_wbin_w[PTR_WIDTH:0];

    // Empty when the read pointer catches the synchronized write pointer
    assign rempty_next = (rgray_next == rq2_wgray);
    assign rfill_next  = rq2_wbin - rbin_next;  // Wraps modulo 2**(PTR_WIDTH+1)

    // Two-flop synchronizer for the write pointer
    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= i_wgray;
            rq2_wgray <= rq1_wgray;
        end
    end

    always_ff @(posedge i_rclk or negedge i_rrstn) begin
        if (!i_rrstn) begin
            rbin           <= '0;
            o_rgray        <= '0;
            o_rempty       <= 1'b1;
            o_ralmostempty <= 1'b1;
            o_rfill        <= '0;
        end else begin
            rbin           <= rbin_next;
            o_rgray        <= rgray_next;
            o_rempty       <= rempty_next;
            o_ralmostempty <= (rfill_next <= AE_LEVEL);
            o_rfill        <= rfill_next;
        end
    end

    // Current pointer addresses the oldest word for fall-through
    assign mem_if.raddr = rbin[PTR_WIDTH-1:0];

endmodule : fifo_rd_ctrl

// ==== hdl/fifo_async_top.sv ====
// Dual-clock FIFO top level
// Write and read pointer controllers exchange Gray pointers across the
// clock domains and share the storage array through one interface

`timescale 1ns/10ps

module fifo_async_top import fifo_cfg_pkg::*; #(
    parameter int DATA_WIDTH         = DEF_DATA_WIDTH,
    parameter int PTR_WIDTH          = DEF_PTR_WIDTH,
    parameter int ALMOSTFULL_OFFSET  = DEF_ALMOSTFULL_OFFSET,
    parameter int ALMOSTEMPTY_OFFSET = DEF_ALMOSTEMPTY_OFFSET
) (
    // Write side
    input  logic                  i_wclk,
    input  logic                  i_wrstn,
    input  logic                  i_wr,
    input  logic [DATA_WIDTH-1:0] i_wdata,
    output logic                  o_wfull,
    output logic                  o_walmostfull,
    output logic [PTR_WIDTH:0]    o_wfill,

    // Read side
    input  logic                  i_rclk,
    input  logic                  i_rrstn,
    input  logic                  i_rd,
    output logic [DATA_WIDTH-1:0] o_rdata,        // Oldest word while not empty
    output logic                  o_rempty,
    output logic                  o_ralmostempty,
    output logic [PTR_WIDTH:0]    o_rfill
);

    logic [PTR_WIDTH:0] wgray;  // Write pointer into the read domain
    logic [PTR_WIDTH:0] rgray;  // Read pointer into the write domain

    fifo_mem_if #(
        .DATA_WIDTH (DATA_WIDTH),
        .PTR_WIDTH  (PTR_WIDTH)
    ) mem_if ();

    assign mem_if.wdata = i_wdata;
    assign o_rdata      = mem_if.rdata;

    fifo_dpram #(
        .DATA_WIDTH (DATA_WIDTH),
        .PTR_WIDTH  (PTR_WIDTH)
    ) dpram_i (
        .i_wclk (i_wclk),
        .mem_if (mem_if.mem_port)
    );

    fifo_wr_ctrl #(
        .PTR_WIDTH         (PTR_WIDTH),
        .ALMOSTFULL_OFFSET (ALMOSTFULL_OFFSET)
    ) wr_ctrl_i (
        .i_wclk        (i_wclk),
        .i_wrstn       (i_wrstn),
        .i_wr          (i_wr),
        .i_rgray       (rgray),
        .o_wgray       (wgray),
        .o_wfull       (o_wfull),
        .o_walmostfull (o_walmostfull),
        .o_wfill       (o_wfill),
        .mem_if        (mem_if.wr_port)
    );

    fifo_rd_ctrl #(
        .PTR_WIDTH          (PTR_WIDTH),
        .ALMOSTEMPTY_OFFSET (ALMOSTEMPTY_OFFSET)
    ) rd_ctrl_i (
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .i_wgray        (wgray),
        .o_rgray        (rgray),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill),
        .mem_if         (mem_if.rd_port)
    );

endmodule : fifo_async_top

// ==== dv/fifo_async_tb.sv ====
// Dual-clock FIFO testbench
// Fill, drain and random traffic against a reference queue, with
// concurrent assertions on ordering, flags and fill levels

`timescale 1ns/10ps

module fifo_async_tb import fifo_cfg_pkg::*; ();

    localparam int DATA_WIDTH = DEF_DATA_WIDTH;
    localparam int PTR_WIDTH  = DEF_PTR_WIDTH;
    localparam int AF_OFFSET  = DEF_ALMOSTFULL_OFFSET;
    localparam int AE_OFFSET  = DEF_ALMOSTEMPTY_OFFSET;
    localparam int DEPTH      = 1 << PTR_WIDTH;
    localparam int FILL_W     = PTR_WIDTH + 1;

    localparam logic [PTR_WIDTH:0] DEPTH_W  = FILL_W'(DEPTH);
    localparam logic [PTR_WIDTH:0] AF_LEVEL = FILL_W'(DEPTH - AF_OFFSET);
    localparam logic [PTR_WIDTH:0] AE_LEVEL = FILL_W'(AE_OFFSET);

    localparam realtime WCLK_HALF = 4.0;  // 8 ns write clock
    localparam realtime RCLK_HALF = 5.5;  // 11 ns read clock

    localparam int          RESET_CYCLES      = 5;
    localparam int          FILL_WRITES       = 40;
    localparam int          TRAFFIC_CYCLES    = 2000;
    localparam int          RD_TRAFFIC_CYCLES = 1455;  // Same span as 2000 write cycles
    localparam int          RATE_SPAN         = 200;   // Cycles between rate changes
    localparam int          TIMEOUT_CYCLES    = 3000;
    localparam logic [31:0] RNG_SEED          = 32'h6f2b765f;

    logic                  i_wclk;
    logic                  i_wrstn;
    logic                  i_wr;
    logic [DATA_WIDTH-1:0] i_wdata;
    logic                  o_wfull;
    logic                  o_walmostfull;
    logic [PTR_WIDTH:0]    o_wfill;
    logic                  i_rclk;
    logic                  i_rrstn;
    logic                  i_rd;
    logic [DATA_WIDTH-1:0] o_rdata;
    logic                  o_rempty;
    logic                  o_ralmostempty;
    logic [PTR_WIDTH:0]    o_rfill;

    // Reference model
    logic [DATA_WIDTH-1:0] ref_q[$];
    logic [PTR_WIDTH:0]    ref_count;   // Queue size, updated after each edge
    logic [DATA_WIDTH-1:0] ref_front;   // Oldest stored word
    logic                  tail_check;  // Both sides quiet and settled
    int                    cycle_count;

    fifo_async_top dut_i (
        .i_wclk         (i_wclk),
        .i_wrstn        (i_wrstn),
        .i_wr           (i_wr),
        .i_wdata        (i_wdata),
        .o_wfull        (o_wfull),
        .o_walmostfull  (o_walmostfull),
        .o_wfill        (o_wfill),
        .i_rclk         (i_rclk),
        .i_rrstn        (i_rrstn),
        .i_rd           (i_rd),
        .o_rdata        (o_rdata),
        .o_rempty       (o_rempty),
        .o_ralmostempty (o_ralmostempty),
        .o_rfill        (o_rfill)
    );

    initial begin
        i_wclk = 1'b0;
        forever #WCLK_HALF i_wclk = ~i_wclk;
    end

    initial begin
        i_rclk = 1'b0;
        forever #RCLK_HALF i_rclk = ~i_rclk;
    end

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopped at the first failing check");
    endtask

    // Run limit in write clock cycles
    initial cycle_count = 0;
    always @(posedge i_wclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation did not finish within %0d write clock cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "Run limit reached");
        end
    end

    task automatic refresh_ref_view();
        ref_count <= FILL_W'(ref_q.size());
        ref_front <= (ref_q.size() > 0) ? ref_q[0] : '0;
    endtask

    // Same acceptance rules as the FIFO handshake
    always @(posedge i_wclk) begin
        if (i_wrstn && i_wr && !o_wfull) begin
            ref_q.push_back(i_wdata);
            refresh_ref_view();
        end
    end

    always @(posedge i_rclk) begin
        if (i_rrstn && i_rd && !o_rempty && ref_q.size() > 0) begin
            void'(ref_q.pop_front());
            refresh_ref_view();
        end
    end

    // Reset values, during reset and on the first edge after release
    assert property (@(posedge i_wclk) (!i_wrstn || $rose(i_wrstn)) |->
                     (!o_wfull && !o_walmostfull && o_wfill == '0))
        else report_mismatch("write side flags or fill not at reset values");
    assert property (@(posedge i_rclk) (!i_rrstn || $rose(i_rrstn)) |->
                     (o_rempty && o_ralmostempty && o_rfill == '0))
        else report_mismatch("read side flags or fill not at reset values");

    // Ordering against the reference queue
    assert property (@(posedge i_rclk) disable iff (!i_rrstn)
                     (i_rd && !o_rempty) |-> (ref_count != '0))
        else report_mismatch("read accepted while the reference queue is empty");
    assert property (@(posedge i_rclk) disable iff (!i_rrstn)
                     (i_rd && !o_rempty) |-> (o_rdata == ref_front))
        else report_mismatch($sformatf("o_rdata 0x%0h, expected 0x%0h",
                                       $sampled(o_rdata), $sampled(ref_front)));

    // Full, empty and fill bounds
    assert property (@(posedge i_wclk) disable iff (!i_wrstn)
                     o_wfull == (o_wfill == DEPTH_W))
        else report_mismatch($sformatf("o_wfull %0b with o_wfill %0d",
                                       $sampled(o_wfull), $sampled(o_wfill)));
    assert property (@(posedge i_rclk) disable iff (!i_rrstn)
                     o_rempty == (o_rfill == '0))
        else report_mismatch($sformatf("o_rempty %0b with o_rfill %0d",
                                       $sampled(o_rempty), $sampled(o_rfill)));
    assert property (@(posedge i_wclk) disable iff (!i_wrstn) o_wfill <= DEPTH_W)
        else report_mismatch($sformatf("o_wfill %0d above depth", $sampled(o_wfill)));
    assert property (@(posedge i_rclk) disable iff (!i_rrstn) o_rfill <= DEPTH_W)
        else report_mismatch($sformatf("o_rfill %0d above depth", $sampled(o_rfill)));

    // Almost flags
    assert property (@(posedge i_wclk) disable iff (!i_wrstn)
                     o_walmostfull == (o_wfill >= AF_LEVEL))
        else report_mismatch($sformatf("o_walmostfull %0b with o_wfill %0d",
                                       $sampled(o_walmostfull), $sampled(o_wfill)));
    assert property (@(posedge i_rclk) disable iff (!i_rrstn)
                     o_ralmostempty == (o_rfill <= AE_LEVEL))
        else report_mismatch($sformatf("o_ralmostempty %0b with o_rfill %0d",
                                       $sampled(o_ralmostempty), $sampled(o_rfill)));

    // Back-pressure and settled fill levels
    assert property (@(posedge i_wclk) disable iff (!i_wrstn)
                     (i_wr && o_wfull) |=> (o_wfill <= $past(o_wfill)))
        else report_mismatch($sformatf("write while full grew o_wfill to %0d",
                                       $sampled(o_wfill)));
    assert property (@(posedge i_wclk) disable iff (!i_wrstn)
                     tail_check |-> (o_wfill == ref_count))
        else report_mismatch($sformatf("settled o_wfill %0d, expected %0d",
                                       $sampled(o_wfill), $sampled(ref_count)));
    assert property (@(posedge i_rclk) disable iff (!i_rrstn)
                     tail_check |-> (o_rfill == ref_count))
        else report_mismatch($sformatf("settled o_rfill %0d, expected %0d",
                                       $sampled(o_rfill), $sampled(ref_count)));

    task automatic drive_write_traffic();
        int unsigned wr_pct;
        wr_pct = 50;
        for (int i = 0; i < TRAFFIC_CYCLES; i++) begin
            if (i % RATE_SPAN == 0) begin
                wr_pct = $urandom_range(85, 15);  // New write rate per span
            end
            @(posedge i_wclk);
            i_wr    <= ($urandom_range(99, 0) < wr_pct);
            i_wdata <= DATA_WIDTH'($urandom());
        end
        @(posedge i_wclk);
        i_wr <= 1'b0;
    endtask

    task automatic drive_read_traffic();
        int unsigned rd_pct;
        rd_pct = 50;
        for (int i = 0; i < RD_TRAFFIC_CYCLES; i++) begin
            if (i % RATE_SPAN == 0) begin
                rd_pct = $urandom_range(85, 15);
            end
            @(posedge i_rclk);
            i_rd <= ($urandom_range(99, 0) < rd_pct);
        end
        @(posedge i_rclk);
        i_rd <= 1'b0;
    endtask

    initial begin
        i_wrstn     = 1'b1;
        i_rrstn     = 1'b1;
        i_wr        = 1'b0;
        i_wdata     = '0;
        i_rd        = 1'b0;
        ref_count   = '0;
        ref_front   = '0;
        tail_check  = 1'b0;
        void'($urandom(RNG_SEED));

        // Falling reset edge before the first clock edge
        #1;
        i_wrstn = 1'b0;
        i_rrstn = 1'b0;

        repeat (RESET_CYCLES) @(posedge i_wclk);
        i_wrstn <= 1'b1;
        @(posedge i_rclk);
        i_rrstn <= 1'b1;
        repeat (2) @(posedge i_wclk);

        // Fill past full with the read side idle
        repeat (FILL_WRITES) begin
            @(posedge i_wclk);
            i_wr    <= 1'b1;
            i_wdata <= DATA_WIDTH'($urandom());
        end
        @(posedge i_wclk);
        i_wr <= 1'b0;
        if (!o_wfull) begin
            report_mismatch("fill phase ended without o_wfull");
        end

        // Drain, then keep reading a few cycles while empty
        @(posedge i_rclk);
        i_rd <= 1'b1;
        do begin
            @(posedge i_rclk);
        end while (!o_rempty);
        repeat (4) @(posedge i_rclk);
        i_rd <= 1'b0;
        repeat (4) @(posedge i_wclk);

        fork
            drive_write_traffic();
            drive_read_traffic();
        join

        // Quiet tail
        repeat (4) @(posedge i_wclk);
        repeat (4) @(posedge i_rclk);
        tail_check <= 1'b1;
        repeat (4) @(posedge i_wclk);
        repeat (4) @(posedge i_rclk);

        $display("No errors");
        $finish;
    end

endmodule : fifo_async_tb

// ==== tb.f ====
hdl/fifo_cfg_pkg.sv
hdl/fifo_ptr_pkg.sv
hdl/fifo_mem_if.sv
hdl/fifo_dpram.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/fifo_async_top.sv
dv/fifo_async_tb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= fifo_async_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: sim clean

# Build the model, then run it; a $fatal in the run gives a failing status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
